// ==== Bender.yml ====
package:
  name: frame_check

sources:
  - include_dirs:
      - design
    files:
      - design/frame_check_pkg.sv
      - design/frame_link_if.sv
      - design/credit_fifo.sv
      - design/crc16_engine.sv
      - design/frame_checker.sv
      - design/verdict_reporter.sv
      - design/frame_check_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_frame_check.sv

// ==== bench/tb_frame_check.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

module tb_frame_check;

	localparam logic [31:0] RNG_SEED = 32'hc0871e8f;
	// words per test: 6, 6, 3 + 6, 4 x 4, 3 x 7
	localparam int TOTAL_WORDS    = 6 + 6 + 9 + 16 + 21;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_WORDS + 200;

	logic                        clk = 1'b0;
	logic                        i_arst_n;
	logic                        i_word_valid;
	logic                        i_word_sof;
	logic [31:0]                 i_word_data;
	logic                        o_word_credit;
	logic [`FC_FRAME_SIZE_W-1:0] i_frame_size;
	logic                        o_overflow;
	logic                        o_verdict_valid;
	logic                        o_verdict_good;
	logic                        o_verdict_truncated;
	logic [`FC_COUNT_W-1:0]      o_verdict_frame_no;
	logic                        i_verdict_credit;
	logic [`FC_COUNT_W-1:0]      o_good_count;
	logic [`FC_COUNT_W-1:0]      o_bad_count;

	// scoreboard state
	frame_check_pkg::verdict_t obs_q[$];
	frame_check_pkg::verdict_t exp_q[$];
	int error_count        = 0;
	int tests_run          = 0;
	int tests_failed       = 0;
	int words_sent         = 0;
	int credit_pulses      = 0;
	int verdicts_seen      = 0;
	int verdicts_returned  = 0;
	int frame_count        = 0;
	int exp_good           = 0;
	int exp_bad            = 0;
	int errors_at_start    = 0;
	int words_at_start     = 0;
	int pulses_at_start    = 0;
	int cycle_count        = 0;
	bit return_credits     = 1'b1;

	frame_check_top u_dut (
		.clk                 (clk),
		.i_arst_n            (i_arst_n),
		.i_word_valid        (i_word_valid),
		.i_word_sof          (i_word_sof),
		.i_word_data         (i_word_data),
		.o_word_credit       (o_word_credit),
		.i_frame_size        (i_frame_size),
		.o_overflow          (o_overflow),
		.o_verdict_valid     (o_verdict_valid),
		.o_verdict_good      (o_verdict_good),
		.o_verdict_truncated (o_verdict_truncated),
		.o_verdict_frame_no  (o_verdict_frame_no),
		.i_verdict_credit    (i_verdict_credit),
		.o_good_count        (o_good_count),
		.o_bad_count         (o_bad_count)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// monitors and credit return
	// ------------------------------------------------------------------------

	// registered outputs, read before the edge updates them
	always @(posedge clk) begin
		if (o_word_credit) begin
			credit_pulses++;
		end
		if (o_verdict_valid) begin
			obs_q.push_back('{good: o_verdict_good, truncated: o_verdict_truncated,
				frame_no: o_verdict_frame_no});
			verdicts_seen++;
		end
	end

	// one output credit back per received verdict, when enabled
	initial begin
		i_verdict_credit = 1'b0;
		forever begin
			@(negedge clk);
			if (return_credits && verdicts_returned < verdicts_seen) begin
				i_verdict_credit = 1'b1;
				verdicts_returned++;
			end else begin
				i_verdict_credit = 1'b0;
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// crc-16-ccitt over one word, msb first
	function automatic logic [15:0] crc_step_word(logic [15:0] crc_in, logic [31:0] word);
		logic [15:0] c;
		logic        bit_in;
		c = crc_in;
		for (int b = 31; b >= 0; b--) begin
			bit_in = word[b] ^ c[15];
			c = {c[14:0], 1'b0} ^ ({16{bit_in}} & `FC_CRC_POLY);
		end
		return c;
	endfunction

	task automatic check_equal(string name, logic [31:0] got, logic [31:0] want);
		assert (got === want) else begin
			$display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
			error_count++;
		end
	endtask

	// called on a falling edge, holds off while no input credit is left
	task automatic push_word(logic sof, logic [31:0] data);
		while (`FC_WORD_FIFO_DEPTH - words_sent + credit_pulses <= 0) begin
			@(negedge clk);
		end
		i_word_valid = 1'b1;
		i_word_sof   = sof;
		i_word_data  = data;
		words_sent++;
		@(negedge clk);
		i_word_valid = 1'b0;
		i_word_sof   = 1'b0;
	endtask

	task automatic expect_verdict(logic good, logic truncated);
		exp_q.push_back('{good: good, truncated: truncated, frame_no: 16'(frame_count)});
		if (good) begin
			exp_good++;
		end else begin
			exp_bad++;
		end
	endtask

	// random payload, check word xor flip, zero flip means a good frame
	task automatic send_frame(int n_payload, logic [31:0] flip);
		logic [15:0] crc;
		logic [31:0] data;
		crc = `FC_CRC_INIT;
		frame_count++;
		for (int i = 0; i < n_payload; i++) begin
			data = $urandom;
			crc  = crc_step_word(crc, data);
			push_word(i == 0, data);
		end
		push_word(1'b0, {crc, crc} ^ flip);
		expect_verdict(flip == 32'h0, 1'b0);
	endtask

	// frame without check word, closed by the next sof
	task automatic send_partial(int n_words);
		frame_count++;
		for (int i = 0; i < n_words; i++) begin
			push_word(i == 0, $urandom);
		end
		expect_verdict(1'b0, 1'b1);
	endtask

	task automatic wait_for_verdicts(int n);
		while (obs_q.size() < n) begin
			@(negedge clk);
		end
	endtask

	task automatic check_next_verdict();
		frame_check_pkg::verdict_t got;
		frame_check_pkg::verdict_t want;
		assert (obs_q.size() > 0 && exp_q.size() > 0) else begin
			$display("at %0t: no verdict left to compare", $time);
			error_count++;
			return;
		end
		got  = obs_q.pop_front();
		want = exp_q.pop_front();
		check_equal("o_verdict_good", got.good, want.good);
		check_equal("o_verdict_truncated", got.truncated, want.truncated);
		check_equal("o_verdict_frame_no", got.frame_no, want.frame_no);
	endtask

	task automatic start_test();
		errors_at_start = error_count;
		words_at_start  = words_sent;
		pulses_at_start = credit_pulses;
	endtask

	// credit balance and overflow hold for every test
	task automatic close_test(string name);
		repeat (4) @(negedge clk);
		check_equal("o_word_credit pulse count", credit_pulses - pulses_at_start,
			words_sent - words_at_start);
		assert (!o_overflow) else begin
			$display("at %0t: o_overflow went high although credits were respected", $time);
			error_count++;
		end
		tests_run++;
		if (error_count != errors_at_start) begin
			tests_failed++;
			$display("test %-22s FAIL (%0d checks)", name, error_count - errors_at_start);
		end else begin
			$display("test %-22s PASS", name);
		end
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	task automatic reset_values();
		start_test();
		check_equal("o_word_credit", o_word_credit, 1'b0);
		check_equal("o_verdict_valid", o_verdict_valid, 1'b0);
		check_equal("o_overflow", o_overflow, 1'b0);
		check_equal("o_good_count", o_good_count, 0);
		check_equal("o_bad_count", o_bad_count, 0);
		close_test("reset_values");
	endtask

	task automatic single_good_frame();
		start_test();
		i_frame_size = 5;
		send_frame(5, 32'h0);
		wait_for_verdicts(1);
		check_next_verdict();
		close_test("single_good_frame");
	endtask

	// bad total so far includes this frame
	task automatic corrupted_check_word();
		start_test();
		send_frame(5, 32'h0000_0400);
		wait_for_verdicts(1);
		check_next_verdict();
		check_equal("o_bad_count", o_bad_count, exp_bad);
		close_test("corrupted_check_word");
	endtask

	// open frame cut after 3 words, next frame complete
	task automatic truncated_frame();
		start_test();
		send_partial(3);
		send_frame(5, 32'h0);
		wait_for_verdicts(2);
		check_next_verdict();
		check_next_verdict();
		close_test("truncated_frame");
	endtask

	task automatic verdict_back_pressure();
		start_test();
		// all earlier credits back first
		while (verdicts_returned < verdicts_seen) begin
			@(negedge clk);
		end
		@(posedge clk);
		return_credits = 1'b0;
		@(negedge clk);
		i_frame_size = 3;
		send_frame(3, 32'h0);
		send_frame(3, 32'h0);
		send_frame(3, 32'h0001_0000);
		send_frame(3, 32'h0);
		wait_for_verdicts(`FC_VERDICT_CREDITS);
		repeat (20) @(negedge clk);
		check_equal("verdicts without credit return", obs_q.size(), `FC_VERDICT_CREDITS);
		@(posedge clk);
		return_credits = 1'b1;
		@(negedge clk);
		wait_for_verdicts(4);
		for (int i = 0; i < 4; i++) begin
			check_next_verdict();
		end
		close_test("verdict_back_pressure");
	endtask

	// frames back to back with short random gaps
	task automatic input_credit_bursts();
		start_test();
		i_frame_size = 6;
		for (int f = 0; f < 3; f++) begin
			send_frame(6, 32'h0);
			repeat ($urandom_range(0, 3)) @(negedge clk);
		end
		wait_for_verdicts(3);
		for (int i = 0; i < 3; i++) begin
			check_next_verdict();
		end
		close_test("input_credit_bursts");
	endtask

	task automatic final_counters();
		start_test();
		check_equal("o_good_count", o_good_count, exp_good);
		check_equal("o_bad_count", o_bad_count, exp_bad);
		close_test("final_counters");
	endtask

	initial begin
		void'($urandom(RNG_SEED));
		i_arst_n     = 1'b0;
		i_word_valid = 1'b0;
		i_word_sof   = 1'b0;
		i_word_data  = 32'h0;
		i_frame_size = '0;
		repeat (10) @(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);

		reset_values();
		single_good_frame();
		corrupted_check_word();
		truncated_frame();
		verdict_back_pressure();
		input_credit_bursts();
		final_counters();

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== design/crc16_engine.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

module crc16_engine (
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_clear,
	input  logic                  i_en,
	input  logic [31:0]           i_data,
	output frame_check_pkg::crc_t o_crc
);

	frame_check_pkg::crc_t crc_q;
	frame_check_pkg::crc_t seed;

	// 32 serial steps, data bit 31 first
	function automatic frame_check_pkg::crc_t fold_word(
		input frame_check_pkg::crc_t crc_in,
		input logic [31:0]           data
	);
		frame_check_pkg::crc_t crc;
		logic                  fb;
		crc = crc_in;
		for (int i = 31; i >= 0; i--) begin
			fb  = crc[15] ^ data[i];
			crc = {crc[14:0], 1'b0};
			if (fb) begin
				crc = crc ^ `FC_CRC_POLY;
			end
		end
		return crc;
	endfunction

	// clear restarts from init, so a sof word folds into a fresh crc
	assign seed = i_clear ? frame_check_pkg::crc_t'(`FC_CRC_INIT) : crc_q;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			crc_q <= `FC_CRC_INIT;
		end else if (i_en) begin
			crc_q <= fold_word(seed, i_data);
		end else if (i_clear) begin
			crc_q <= seed;
		end
	end

	assign o_crc = crc_q;

endmodule

// ==== design/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
	parameter type T_PAYLOAD = logic [31:0],
	parameter int  DEPTH     = 8
) (
	input  logic     clk,
	input  logic     i_arst_n,
	input  logic     i_push,
	input  T_PAYLOAD i_push_data,
	output logic     o_valid,
	output T_PAYLOAD o_data,
	input  logic     i_pop,
	output logic     o_credit,
	output logic     o_overflow
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T_PAYLOAD         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(DEPTH));
	assign o_valid = (count != '0);
	assign o_data  = mem[rd_ptr];
	// push into a full buffer is lost, even with a pop on the same edge
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && o_valid;

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	// pointers, occupancy, credit return
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_credit   <= 1'b0;
			o_overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit per popped entry, a cycle late
			o_credit <= do_pop;
			// sticky until reset
			if (i_push && full) begin
				o_overflow <= 1'b1;
			end
		end
	end

endmodule

// ==== design/frame_check_config.svh ====
`ifndef FRAME_CHECK_CONFIG_SVH
`define FRAME_CHECK_CONFIG_SVH

// input buffer depth, also the sender's starting credits
`define FC_WORD_FIFO_DEPTH 8

// verdict queue depth and output credits at reset
`define FC_VERDICT_FIFO_DEPTH 4
`define FC_VERDICT_CREDITS 2

// widths of frame size, frame number and result counters
`define FC_FRAME_SIZE_W 23
`define FC_COUNT_W 16

// crc-16-ccitt, msb first, no reflection, no final xor
`define FC_CRC_POLY 16'h1021
`define FC_CRC_INIT 16'hFFFF

`endif

// ==== design/frame_check_pkg.sv ====
`include "frame_check_config.svh"

package frame_check_pkg;

	//--------------------------------------------------------------------------
	// stream and result types
	//--------------------------------------------------------------------------

	// one buffered input word
	// sof marks the first payload word of a frame
	typedef struct packed {
		logic        sof;
		logic [31:0] data;
	} word_t;

	// one verdict per frame
	// truncated frames are always reported with good low
	typedef struct packed {
		logic                   good;
		logic                   truncated;
		logic [`FC_COUNT_W-1:0] frame_no;
	} verdict_t;

	// running crc value
	typedef logic [15:0] crc_t;

endpackage

// ==== design/frame_check_top.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

module frame_check_top (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic                        i_word_valid,
	input  logic                        i_word_sof,
	input  logic [31:0]                 i_word_data,
	output logic                        o_word_credit,
	input  logic [`FC_FRAME_SIZE_W-1:0] i_frame_size,
	output logic                        o_overflow,
	output logic                        o_verdict_valid,
	output logic                        o_verdict_good,
	output logic                        o_verdict_truncated,
	output logic [`FC_COUNT_W-1:0]      o_verdict_frame_no,
	input  logic                        i_verdict_credit,
	output logic [`FC_COUNT_W-1:0]      o_good_count,
	output logic [`FC_COUNT_W-1:0]      o_bad_count
);

	frame_check_pkg::word_t push_word;
	frame_check_pkg::word_t head_word;

	word_link_if    u_word_link ();
	verdict_link_if u_verdict_link ();

	// pack sender fields, unpack buffer head onto the link
	assign push_word          = '{sof: i_word_sof, data: i_word_data};
	assign u_word_link.sof    = head_word.sof;
	assign u_word_link.data   = head_word.data;

	// sender holds one credit per free entry
	credit_fifo #(
		.T_PAYLOAD (frame_check_pkg::word_t),
		.DEPTH     (`FC_WORD_FIFO_DEPTH)
	) u_word_fifo (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_push      (i_word_valid),
		.i_push_data (push_word),
		.o_valid     (u_word_link.valid),
		.o_data      (head_word),
		.i_pop       (u_word_link.pop),
		.o_credit    (o_word_credit),
		.o_overflow  (o_overflow)
	);

	frame_checker u_checker (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_frame_size (i_frame_size),
		.word         (u_word_link),
		.verdict      (u_verdict_link)
	);

	verdict_reporter u_reporter (
		.clk                 (clk),
		.i_arst_n            (i_arst_n),
		.verdict             (u_verdict_link),
		.o_verdict_valid     (o_verdict_valid),
		.o_verdict_good      (o_verdict_good),
		.o_verdict_truncated (o_verdict_truncated),
		.o_verdict_frame_no  (o_verdict_frame_no),
		.i_verdict_credit    (i_verdict_credit),
		.o_good_count        (o_good_count),
		.o_bad_count         (o_bad_count)
	);

endmodule

// ==== design/frame_checker.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

module frame_checker (
	input  logic                       clk,
	input  logic                       i_arst_n,
	input  logic [`FC_FRAME_SIZE_W-1:0] i_frame_size,
	word_link_if.snk                   word,
	verdict_link_if.src                verdict
);

	logic [`FC_FRAME_SIZE_W-1:0] size_q;
	logic [`FC_FRAME_SIZE_W-1:0] word_idx;
	logic [`FC_COUNT_W-1:0]      frame_no;
	logic                        in_frame;
	logic                        is_sof;
	logic                        is_body;
	logic                        is_check;
	logic                        crc_en;
	logic                        crc_match;
	frame_check_pkg::crc_t       crc;
	logic                        verdict_valid_q;
	logic                        good_q;
	logic                        trunc_q;
	logic [`FC_COUNT_W-1:0]      frame_no_q;

	// checker never stalls
	assign word.pop = word.valid;

	//--------------------------------------------------------------------------
	// word classification
	//--------------------------------------------------------------------------

	assign is_sof   = word.valid && word.sof;
	// non-sof words outside a frame fall through and are dropped
	assign is_body  = word.valid && !word.sof && in_frame;
	// sof word is index 0, so the check word sits at index frame size
	assign is_check = is_body && (word_idx == size_q);
	// check word itself stays out of the crc
	assign crc_en   = is_sof || (is_body && !is_check);
	// check word carries the crc in both halves
	assign crc_match = (word.data == {crc, crc});

	crc16_engine u_crc (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_clear  (is_sof),
		.i_en     (crc_en),
		.i_data   (word.data),
		.o_crc    (crc)
	);

	//--------------------------------------------------------------------------
	// frame tracking
	//--------------------------------------------------------------------------

	// frame size of zero is not supported, index starts at one after sof
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			in_frame        <= 1'b0;
			size_q          <= '0;
			word_idx        <= '0;
			frame_no        <= '0;
			verdict_valid_q <= 1'b0;
		end else begin
			// early sof closes the open frame as truncated
			verdict_valid_q <= is_check || (is_sof && in_frame);
			if (is_sof) begin
				in_frame <= 1'b1;
				size_q   <= i_frame_size;
				word_idx <= `FC_FRAME_SIZE_W'(1);
				frame_no <= frame_no + 1'b1;
			end else if (is_check) begin
				in_frame <= 1'b0;
			end else if (is_body) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// verdict payload, sampled with the old frame number
	always_ff @(posedge clk) begin
		if (is_sof) begin
			good_q     <= 1'b0;
			trunc_q    <= 1'b1;
			frame_no_q <= frame_no;
		end else if (is_check) begin
			good_q     <= crc_match;
			trunc_q    <= 1'b0;
			frame_no_q <= frame_no;
		end
	end

	assign verdict.valid     = verdict_valid_q;
	assign verdict.good      = good_q;
	assign verdict.truncated = trunc_q;
	assign verdict.frame_no  = frame_no_q;

endmodule

// ==== design/frame_link_if.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

//----------------------------------------------------------------------------
// buffer head to checker
//----------------------------------------------------------------------------

// pop is high exactly when valid is high
// head entry leaves on that edge
interface word_link_if;
	logic        valid;
	logic        sof;
	logic [31:0] data;
	logic        pop;

	modport src (output valid, output sof, output data, input pop);
	modport snk (input valid, input sof, input data, output pop);
endinterface

//----------------------------------------------------------------------------
// checker to reporter
//----------------------------------------------------------------------------

// valid is a single-cycle pulse, no back-pressure
interface verdict_link_if;
	logic                   valid;
	logic                   good;
	logic                   truncated;
	logic [`FC_COUNT_W-1:0] frame_no;

	modport src (output valid, output good, output truncated, output frame_no);
	modport snk (input valid, input good, input truncated, input frame_no);
endinterface

// ==== design/verdict_reporter.sv ====
`timescale 1ns/1ps
`include "frame_check_config.svh"

module verdict_reporter (
	input  logic                   clk,
	input  logic                   i_arst_n,
	verdict_link_if.snk            verdict,
	output logic                   o_verdict_valid,
	output logic                   o_verdict_good,
	output logic                   o_verdict_truncated,
	output logic [`FC_COUNT_W-1:0] o_verdict_frame_no,
	input  logic                   i_verdict_credit,
	output logic [`FC_COUNT_W-1:0] o_good_count,
	output logic [`FC_COUNT_W-1:0] o_bad_count
);

	// headroom above the reset credits
	localparam int CREDIT_W = $clog2(`FC_VERDICT_CREDITS + 1) + 1;

	frame_check_pkg::verdict_t in_verdict;
	frame_check_pkg::verdict_t head_verdict;
	logic                      head_valid;
	logic                      send;
	logic [CREDIT_W-1:0]       credits;

	assign in_verdict = '{
		good:      verdict.good,
		truncated: verdict.truncated,
		frame_no:  verdict.frame_no
	};

	// verdicts wait here in order while credits are out
	credit_fifo #(
		.T_PAYLOAD (frame_check_pkg::verdict_t),
		.DEPTH     (`FC_VERDICT_FIFO_DEPTH)
	) u_verdict_fifo (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_push      (verdict.valid),
		.i_push_data (in_verdict),
		.o_valid     (head_valid),
		.o_data      (head_verdict),
		.i_pop       (send),
		.o_credit    (),
		.o_overflow  ()
	);

	assign send = head_valid && (credits != '0);

	//--------------------------------------------------------------------------
	// output credits and result port
	//--------------------------------------------------------------------------

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			credits         <= CREDIT_W'(`FC_VERDICT_CREDITS);
			o_verdict_valid <= 1'b0;
		end else begin
			case ({send, i_verdict_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			o_verdict_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			o_verdict_good      <= head_verdict.good;
			o_verdict_truncated <= head_verdict.truncated;
			o_verdict_frame_no  <= head_verdict.frame_no;
		end
	end

	// counted on arrival, not on send, wrap at width
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_good_count <= '0;
			o_bad_count  <= '0;
		end else if (verdict.valid) begin
			if (verdict.good) begin
				o_good_count <= o_good_count + 1'b1;
			end else begin
				o_bad_count <= o_bad_count + 1'b1;
			end
		end
	end

endmodule

// ==== sources.f ====
+incdir+design
design/frame_check_pkg.sv
design/frame_link_if.sv
design/credit_fifo.sv
design/crc16_engine.sv
design/frame_checker.sv
design/verdict_reporter.sv
design/frame_check_top.sv
bench/tb_frame_check.sv
